// File: usb_dump_pkg.sv
`default_nettype none

package usb_dump_pkg;

    localparam int buf_bit_addr_w  = 13;   // 8k single bits
    localparam int buf_byte_addr_w = 10;   // 1k bytes
    localparam int rom_addr_w      = 7;
    localparam int page_w          = 12;   // three hex digits

    typedef logic [7:0] byte_t;

    localparam byte_t ascii_cr    = 8'h0D;
    localparam byte_t ascii_space = 8'h20;

    localparam int boot_title_len = 16;
    localparam int user_title_len = 10;

    localparam logic [8*boot_title_len-1:0] boot_title = "BOOT LOADER DUMP";
    localparam logic [8*user_title_len-1:0] user_title = "USER PAGE ";   // page digits follow

    // text ROM map
    localparam logic [rom_addr_w-1:0] rom_hex_base  = 7'h00;   // "0".."9", "A".."F"
    localparam logic [rom_addr_w-1:0] rom_boot_base = 7'h10;
    localparam logic [rom_addr_w-1:0] rom_user_base = 7'h50;

    typedef enum logic [3:0] {
        idle,
        title_fetch,
        title_send,
        page_fetch,
        page_send,
        page_end,
        byte_fetch,
        hi_send,
        lo_send,
        space_send,
        line_end,
        final_end,
        wait_release
    } dump_state_t;

endpackage

`default_nettype wire

// File: text_rom.sv
`default_nettype none

module text_rom (
    input  wire                                 MCLK,
    input  wire  [usb_dump_pkg::rom_addr_w-1:0] rom_addr,
    output usb_dump_pkg::byte_t                 rom_data
);

    localparam int aw = usb_dump_pkg::rom_addr_w;

    usb_dump_pkg::byte_t mem [2**aw];

    initial begin
        for (int i = 0; i < 2**aw; i++) begin
            mem[i[aw-1:0]] = 8'h00;   // unused locations read as NUL
        end

        for (int i = 0; i < 16; i++) begin
            if (i < 10) begin
                mem[usb_dump_pkg::rom_hex_base + i[aw-1:0]] = 8'h30 + i[7:0];   // '0'..'9'
            end else begin
                mem[usb_dump_pkg::rom_hex_base + i[aw-1:0]] = 8'h37 + i[7:0];   // 'A'..'F'
            end
        end

        // titles are packed strings, first character in the top byte
        for (int i = 0; i < usb_dump_pkg::boot_title_len; i++) begin
            mem[usb_dump_pkg::rom_boot_base + i[aw-1:0]] =
                usb_dump_pkg::boot_title[8*(usb_dump_pkg::boot_title_len-1-i) +: 8];
        end
        for (int i = 0; i < usb_dump_pkg::user_title_len; i++) begin
            mem[usb_dump_pkg::rom_user_base + i[aw-1:0]] =
                usb_dump_pkg::user_title[8*(usb_dump_pkg::user_title_len-1-i) +: 8];
        end
    end

    always_ff @(posedge MCLK) begin
        rom_data <= mem[rom_addr];   // one cycle read latency
    end

endmodule

`default_nettype wire

// File: sipo_buffer.sv
`default_nettype none

module sipo_buffer (
    input  wire                                      MCLK,
    input  wire                                      buf_wr_en,
    input  wire  [usb_dump_pkg::buf_bit_addr_w-1:0]  buf_wr_addr,
    input  wire                                      buf_wr_bit,
    input  wire  [usb_dump_pkg::buf_byte_addr_w-1:0] rd_addr,
    output usb_dump_pkg::byte_t                      rd_data
);

    usb_dump_pkg::byte_t mem [2**usb_dump_pkg::buf_byte_addr_w];

    logic [usb_dump_pkg::buf_byte_addr_w-1:0] wr_byte_addr;
    usb_dump_pkg::byte_t                      wr_byte;

    // bit address a lands in bit a mod 8 of byte a / 8
    always_comb begin
        wr_byte_addr = buf_wr_addr[usb_dump_pkg::buf_bit_addr_w-1:3];
        wr_byte      = mem[wr_byte_addr];                 // read the old byte
        wr_byte[buf_wr_addr[2:0]] = buf_wr_bit;           // merge the new bit
    end

    always_ff @(posedge MCLK) begin
        if (buf_wr_en) begin
            mem[wr_byte_addr] <= wr_byte;
        end
        rd_data <= mem[rd_addr];   // registered byte read
    end

endmodule

`default_nettype wire

// File: fifo_writer.sv
`default_nettype none

module fifo_writer (
    input  wire                  MCLK,
    input  wire                  reset,
    input  wire                  char_valid,
    input  wire  usb_dump_pkg::byte_t char_data,
    output logic                 char_ready,
    input  wire                  txe_n,
    output usb_dump_pkg::byte_t  fifo_data,
    output logic                 wr_n
);

    typedef enum logic [1:0] {
        wr_empty,
        wr_wait_txe,
        wr_strobe
    } wr_state_t;

    wr_state_t state;
    logic      strobe_hold;   // set in the second strobe cycle

    assign char_ready = (state == wr_empty);

    always_ff @(posedge MCLK) begin
        if (reset) begin
            state       <= wr_empty;
            wr_n        <= 1'b1;
            fifo_data   <= '0;
            strobe_hold <= 1'b0;
        end else begin
            case (state)
                wr_empty: begin
                    if (char_valid) begin
                        fifo_data <= char_data;   // held until the strobe ends
                        state     <= wr_wait_txe;
                    end
                end
                wr_wait_txe: begin
                    if (!txe_n) begin
                        wr_n        <= 1'b0;
                        strobe_hold <= 1'b0;
                        state       <= wr_strobe;
                    end
                end
                wr_strobe: begin
                    if (!strobe_hold) begin
                        strobe_hold <= 1'b1;
                    end else begin
                        wr_n  <= 1'b1;   // byte is taken on this rising edge
                        state <= wr_empty;
                    end
                end
                default: state <= wr_empty;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: dump_sequencer.sv
`default_nettype none

module dump_sequencer #(
    parameter int BOOT_LINES     = 30,
    parameter int USER_LINES     = 8,
    parameter int BYTES_PER_LINE = 16
) (
    input  wire                                      MCLK,
    input  wire                                      reset,
    input  wire                                      fifo_en,
    input  wire                                      send_boot,
    input  wire                                      send_user,
    input  wire  [usb_dump_pkg::page_w-1:0]          page,
    output logic [usb_dump_pkg::rom_addr_w-1:0]      rom_addr,
    output logic [usb_dump_pkg::buf_byte_addr_w-1:0] rd_addr,
    input  wire  usb_dump_pkg::byte_t                rom_data,
    input  wire  usb_dump_pkg::byte_t                rd_data,
    output logic                                     char_valid,
    output usb_dump_pkg::byte_t                      char_data,
    input  wire                                      char_ready,
    output logic                                     busy
);

    usb_dump_pkg::dump_state_t state;

    logic                            mode_user;    // latched at the start of a dump
    logic [usb_dump_pkg::page_w-1:0] page_q;       // top nibble is the next digit
    logic [7:0]                      byte_cnt;     // also counts title chars and page digits
    logic [7:0]                      line_cnt;
    logic [1:0]                      fetch_cnt;    // buffer then ROM read latency
    logic [7:0]                      title_last;
    logic [7:0]                      line_last;
    logic [7:0]                      byte_last;
    logic                            is_send;
    logic                            xfer;
    usb_dump_pkg::byte_t             send_char;

    always_comb begin
        title_last = mode_user ? 8'(usb_dump_pkg::user_title_len - 1)
                               : 8'(usb_dump_pkg::boot_title_len - 1);
        line_last  = mode_user ? 8'(USER_LINES - 1) : 8'(BOOT_LINES - 1);
        byte_last  = 8'(BYTES_PER_LINE - 1);
        xfer       = char_valid && char_ready;
        busy       = (state != usb_dump_pkg::idle);

        is_send   = 1'b1;
        send_char = rom_data;   // title chars and hex digits come from the ROM
        case (state)
            usb_dump_pkg::page_end,
            usb_dump_pkg::line_end,
            usb_dump_pkg::final_end:  send_char = usb_dump_pkg::ascii_cr;
            usb_dump_pkg::space_send: send_char = usb_dump_pkg::ascii_space;
            usb_dump_pkg::title_send,
            usb_dump_pkg::page_send,
            usb_dump_pkg::hi_send,
            usb_dump_pkg::lo_send:    ;
            default:                  is_send = 1'b0;
        endcase
    end

    always_ff @(posedge MCLK) begin
        if (reset) begin
            state      <= usb_dump_pkg::idle;
            char_valid <= 1'b0;
            mode_user  <= 1'b0;
            byte_cnt   <= '0;
            line_cnt   <= '0;
            fetch_cnt  <= '0;
        end else begin
            // first cycle of a send state offers the char, it stays until taken
            if (is_send && !char_valid) begin
                char_valid <= 1'b1;
                char_data  <= send_char;
            end else if (xfer) begin
                char_valid <= 1'b0;
            end

            case (state)
                usb_dump_pkg::idle: begin
                    if (fifo_en && (send_boot || send_user)) begin
                        mode_user <= !send_boot;   // boot wins
                        page_q    <= page;
                        rom_addr  <= send_boot ? usb_dump_pkg::rom_boot_base
                                               : usb_dump_pkg::rom_user_base;
                        byte_cnt  <= '0;
                        state     <= usb_dump_pkg::title_fetch;
                    end
                end
                usb_dump_pkg::title_fetch: state <= usb_dump_pkg::title_send;
                usb_dump_pkg::title_send: begin
                    if (xfer) begin
                        byte_cnt <= byte_cnt + 8'd1;
                        rom_addr <= rom_addr + 7'd1;
                        state    <= usb_dump_pkg::title_fetch;
                        if (byte_cnt == title_last) begin
                            byte_cnt <= '0;
                            if (mode_user) begin
                                rom_addr <= usb_dump_pkg::rom_hex_base
                                            + {3'b000, page_q[usb_dump_pkg::page_w-1 -: 4]};
                                page_q   <= page_q << 4;
                                state    <= usb_dump_pkg::page_fetch;
                            end else begin
                                rd_addr   <= '0;
                                line_cnt  <= '0;
                                fetch_cnt <= '0;
                                state     <= usb_dump_pkg::byte_fetch;
                            end
                        end
                    end
                end
                usb_dump_pkg::page_fetch: state <= usb_dump_pkg::page_send;
                usb_dump_pkg::page_send: begin
                    if (xfer) begin
                        if (byte_cnt == 8'd2) begin   // msd first, three digits
                            state <= usb_dump_pkg::page_end;
                        end else begin
                            byte_cnt <= byte_cnt + 8'd1;
                            rom_addr <= usb_dump_pkg::rom_hex_base
                                        + {3'b000, page_q[usb_dump_pkg::page_w-1 -: 4]};
                            page_q   <= page_q << 4;
                            state    <= usb_dump_pkg::page_fetch;
                        end
                    end
                end
                usb_dump_pkg::page_end: begin
                    if (xfer) begin
                        byte_cnt  <= '0;
                        rd_addr   <= '0;
                        line_cnt  <= '0;
                        fetch_cnt <= '0;
                        state     <= usb_dump_pkg::byte_fetch;
                    end
                end
                usb_dump_pkg::byte_fetch: begin
                    fetch_cnt <= fetch_cnt + 2'd1;
                    if (fetch_cnt == 2'd1) begin   // rd_data valid here
                        rom_addr <= usb_dump_pkg::rom_hex_base + {3'b000, rd_data[7:4]};
                    end
                    if (fetch_cnt == 2'd2) begin
                        state <= usb_dump_pkg::hi_send;
                    end
                end
                usb_dump_pkg::hi_send: begin
                    // low digit lookup runs while the high digit waits for the writer
                    if (!char_valid) begin
                        rom_addr <= usb_dump_pkg::rom_hex_base + {3'b000, rd_data[3:0]};
                    end else if (xfer) begin
                        state <= usb_dump_pkg::lo_send;
                    end
                end
                usb_dump_pkg::lo_send: begin
                    if (xfer) state <= usb_dump_pkg::space_send;
                end
                usb_dump_pkg::space_send: begin
                    if (xfer) begin
                        rd_addr   <= rd_addr + 10'd1;   // runs on across lines
                        fetch_cnt <= '0;
                        if (byte_cnt == byte_last) begin
                            state <= usb_dump_pkg::line_end;
                        end else begin
                            byte_cnt <= byte_cnt + 8'd1;
                            state    <= usb_dump_pkg::byte_fetch;
                        end
                    end
                end
                usb_dump_pkg::line_end: begin
                    if (xfer) begin
                        byte_cnt <= '0;
                        if (line_cnt == line_last) begin
                            state <= usb_dump_pkg::final_end;
                        end else begin
                            line_cnt  <= line_cnt + 8'd1;
                            fetch_cnt <= '0;
                            state     <= usb_dump_pkg::byte_fetch;
                        end
                    end
                end
                usb_dump_pkg::final_end: begin
                    if (xfer) state <= usb_dump_pkg::wait_release;
                end
                usb_dump_pkg::wait_release: begin
                    if (!send_boot && !send_user) state <= usb_dump_pkg::idle;
                end
                default: state <= usb_dump_pkg::idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: usb_dump_top.sv
`default_nettype none

module usb_dump_top #(
    parameter int BOOT_LINES     = 30,
    parameter int USER_LINES     = 8,
    parameter int BYTES_PER_LINE = 16
) (
    input  wire                                     MCLK,
    input  wire                                     reset,
    input  wire                                     fifo_en,
    input  wire                                     send_boot,
    input  wire                                     send_user,
    input  wire  [usb_dump_pkg::page_w-1:0]         page,
    input  wire                                     buf_wr_en,
    input  wire  [usb_dump_pkg::buf_bit_addr_w-1:0] buf_wr_addr,
    input  wire                                     buf_wr_bit,
    input  wire                                     txe_n,
    output wire  usb_dump_pkg::byte_t               fifo_data,
    output wire                                     wr_n,
    output wire                                     busy
);

    wire [usb_dump_pkg::rom_addr_w-1:0]      rom_addr;
    wire usb_dump_pkg::byte_t                rom_data;
    wire [usb_dump_pkg::buf_byte_addr_w-1:0] rd_addr;
    wire usb_dump_pkg::byte_t                rd_data;
    wire                                     char_valid;    // sequencer to writer
    wire usb_dump_pkg::byte_t                char_data;
    wire                                     char_ready;

    text_rom text_rom_i (
        .MCLK     (MCLK),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    sipo_buffer sipo_buffer_i (
        .MCLK        (MCLK),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_bit  (buf_wr_bit),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    dump_sequencer #(
        .BOOT_LINES     (BOOT_LINES),
        .USER_LINES     (USER_LINES),
        .BYTES_PER_LINE (BYTES_PER_LINE)
    ) dump_sequencer_i (
        .MCLK       (MCLK),
        .reset      (reset),
        .fifo_en    (fifo_en),
        .send_boot  (send_boot),
        .send_user  (send_user),
        .page       (page),
        .rom_addr   (rom_addr),
        .rd_addr    (rd_addr),
        .rom_data   (rom_data),
        .rd_data    (rd_data),
        .char_valid (char_valid),
        .char_data  (char_data),
        .char_ready (char_ready),
        .busy       (busy)
    );

    fifo_writer fifo_writer_i (
        .MCLK       (MCLK),
        .reset      (reset),
        .char_valid (char_valid),
        .char_data  (char_data),
        .char_ready (char_ready),
        .txe_n      (txe_n),
        .fifo_data  (fifo_data),
        .wr_n       (wr_n)
    );

endmodule

`default_nettype wire

// File: usb_dump_assert.sv
`default_nettype none

module usb_dump_assert (
    input wire                 MCLK,
    input wire                 reset,
    input wire                 txe_n,
    input wire                 wr_n,
    input wire usb_dump_pkg::byte_t fifo_data,
    input wire                 char_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // read by the testbench at the end of the run

    // strobe never lasts longer than two cycles
    a_strobe_max: assert property (@(posedge MCLK) disable iff (reset)
        (!wr_n && $past(!wr_n)) |-> $past(wr_n, 2))
    else begin
        fail_count++;
        $error("wr_n held low for more than two cycles");
    end

    // and never shorter than two
    a_strobe_min: assert property (@(posedge MCLK) disable iff (reset)
        $rose(wr_n) |-> $past(!wr_n, 2))
    else begin
        fail_count++;
        $error("wr_n low for less than two cycles");
    end

    a_txe_first: assert property (@(posedge MCLK) disable iff (reset)
        $fell(wr_n) |-> $past(!txe_n))
    else begin
        fail_count++;
        $error("wr_n fell without txe_n low");
    end

    // includes the rising edge where the FIFO takes the byte
    a_data_stable: assert property (@(posedge MCLK) disable iff (reset)
        (!wr_n || $past(!wr_n)) |-> $stable(fifo_data))
    else begin
        fail_count++;
        $error("fifo_data changed during the write strobe");
    end

    a_reset_state: assert property (@(posedge MCLK)
        $fell(reset) |-> (wr_n && char_ready))
    else begin
        fail_count++;
        $error("writer not idle after reset");
    end

endmodule

bind fifo_writer usb_dump_assert usb_dump_assert_i (.*);

`default_nettype wire

// File: tb_usb_dump.sv
`default_nettype none

module tb_usb_dump;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int boot_lines     = 3;
    localparam int user_lines     = 2;
    localparam int bytes_per_line = 16;
    localparam int line_chars     = 3 * bytes_per_line + 1;
    localparam int boot_chars     = usb_dump_pkg::boot_title_len + boot_lines * line_chars + 1;
    localparam int user_chars     = usb_dump_pkg::user_title_len + 4 + user_lines * line_chars + 1;
    localparam int timeout_cycles = (4 * boot_chars + user_chars) * 40 + 2000;

    localparam logic [8*16-1:0] hex_digits = "0123456789ABCDEF";

    logic                                   MCLK;
    logic                                   reset;
    logic                                   fifo_en;
    logic                                   send_boot;
    logic                                   send_user;
    logic [usb_dump_pkg::page_w-1:0]        page;
    logic                                   buf_wr_en;
    logic [usb_dump_pkg::buf_bit_addr_w-1:0] buf_wr_addr;
    logic                                   buf_wr_bit;
    logic                                   txe_n;
    wire usb_dump_pkg::byte_t               fifo_data;
    wire                                    wr_n;
    wire                                    busy;

    logic [31:0]         lfsr = 32'h2783;       // buffer data and page numbers
    logic [31:0]         txe_lfsr = 32'h2783;   // FIFO model only
    logic                txe_random = 1'b0;
    usb_dump_pkg::byte_t buf_model [64];
    usb_dump_pkg::byte_t exp_q [$];
    usb_dump_pkg::byte_t got_q [$];             // every byte the FIFO model took
    int                  cycles = 0;

    usb_dump_top #(
        .BOOT_LINES     (boot_lines),
        .USER_LINES     (user_lines),
        .BYTES_PER_LINE (bytes_per_line)
    ) usb_dump_top_i (
        .MCLK        (MCLK),
        .reset       (reset),
        .fifo_en     (fifo_en),
        .send_boot   (send_boot),
        .send_user   (send_user),
        .page        (page),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_bit  (buf_wr_bit),
        .txe_n       (txe_n),
        .fifo_data   (fifo_data),
        .wr_n        (wr_n),
        .busy        (busy)
    );

    initial begin
        MCLK = 1'b0;
        forever #20 MCLK = ~MCLK;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r    = (r << 1) | {31'd0, lfsr[0]};   // one step per bit
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    function automatic usb_dump_pkg::byte_t hex_char(input logic [3:0] n);
        return hex_digits[8 * (15 - n) +: 8];   // first digit in the top byte
    endfunction

    // FIFO model, TXE low half the time when random
    initial begin
        txe_n = 1'b0;
        forever begin
            @(posedge MCLK);
            #2;
            txe_n    = txe_random & txe_lfsr[0];
            txe_lfsr = lfsr_step(txe_lfsr);
        end
    end

    always @(posedge wr_n) begin
        if (!reset) got_q.push_back(fifo_data);   // byte taken on the rising strobe
    end

    initial begin
        while (cycles < timeout_cycles) begin
            @(posedge MCLK);
            cycles++;
        end
        $display("Timeout: the dump did not complete within %0d cycles", timeout_cycles);
        $display("SOME TESTS FAILED");
        $fatal(1, "run timed out");
    end

    task automatic step();
        @(posedge MCLK);
        #2;
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // write each byte one bit at a time, lsb first
    task automatic fill_buffer(input int nbytes);
        logic [7:0] val;
        int         a;
        int         b;
        for (a = 0; a < nbytes; a++) begin
            val                = 8'(rand_bits(8));
            buf_model[6'(a)]   = val;
            for (b = 0; b < 8; b++) begin
                buf_wr_en   = 1'b1;
                buf_wr_addr = 13'(8 * a + b);
                buf_wr_bit  = val[0];
                val         = val >> 1;
                step();
            end
        end
        buf_wr_en = 1'b0;
    endtask

    task automatic build_expected(input logic user, input logic [11:0] pg);
        usb_dump_pkg::byte_t d;
        int                  lines;
        int                  l;
        int                  b;
        int                  n;
        exp_q.delete();
        lines = user ? user_lines : boot_lines;
        if (user) begin
            for (n = 0; n < usb_dump_pkg::user_title_len; n++) begin
                exp_q.push_back(8'(usb_dump_pkg::user_title >>
                                   (8 * (usb_dump_pkg::user_title_len - 1 - n))));
            end
            exp_q.push_back(hex_char(pg[11:8]));
            exp_q.push_back(hex_char(pg[7:4]));
            exp_q.push_back(hex_char(pg[3:0]));
            exp_q.push_back(usb_dump_pkg::ascii_cr);
        end else begin
            for (n = 0; n < usb_dump_pkg::boot_title_len; n++) begin
                exp_q.push_back(8'(usb_dump_pkg::boot_title >>
                                   (8 * (usb_dump_pkg::boot_title_len - 1 - n))));
            end
        end
        for (l = 0; l < lines; l++) begin
            for (b = 0; b < bytes_per_line; b++) begin
                d = buf_model[6'(l * bytes_per_line + b)];
                exp_q.push_back(hex_char(d[7:4]));
                exp_q.push_back(hex_char(d[3:0]));
                exp_q.push_back(usb_dump_pkg::ascii_space);
            end
            exp_q.push_back(usb_dump_pkg::ascii_cr);
        end
        exp_q.push_back(usb_dump_pkg::ascii_cr);   // closes the dump
    endtask

    task automatic run_dump(input logic user, input logic [11:0] pg);
        int base;
        int i;
        build_expected(user, pg);
        base      = got_q.size();
        fifo_en   = 1'b1;
        send_boot = !user;
        send_user = user;
        page      = pg;
        step();
        check_equal(32'(busy), 32'd1, "busy after request");
        while (got_q.size() - base < exp_q.size()) step();
        repeat (10) step();
        check_equal(32'(busy), 32'd1, "busy while request held");
        check_equal(got_q.size() - base, exp_q.size(), "stream length");
        send_boot = 1'b0;
        send_user = 1'b0;
        while (busy) step();
        for (i = 0; i < exp_q.size(); i++) begin
            check_equal(32'(got_q[base + i]), 32'(exp_q[i]), $sformatf("stream byte %0d", i));
        end
    endtask

    initial begin
        int          base;
        logic [11:0] pg;
        reset       = 1'b1;
        fifo_en     = 1'b1;
        send_boot   = 1'b0;
        send_user   = 1'b0;
        page        = '0;
        buf_wr_en   = 1'b0;
        buf_wr_addr = '0;
        buf_wr_bit  = 1'b0;
        repeat (4) step();
        reset = 1'b0;

        check_equal(32'(wr_n), 32'd1, "wr_n after reset");
        check_equal(32'(busy), 32'd0, "busy after reset");
        check_equal(32'(fifo_data), 32'd0, "fifo_data after reset");

        fill_buffer(boot_lines * bytes_per_line);
        run_dump(1'b0, 12'h000);

        pg = 12'(rand_bits(12));
        run_dump(1'b1, pg);

        txe_random = 1'b1;   // back-pressure from the FIFO
        run_dump(1'b0, 12'h000);
        txe_random = 1'b0;

        // requests are ignored while the FIFO side is off
        base      = got_q.size();
        fifo_en   = 1'b0;
        send_boot = 1'b1;
        repeat (50) begin
            step();
            check_equal(32'(busy), 32'd0, "busy with fifo_en low");
            check_equal(32'(wr_n), 32'd1, "wr_n with fifo_en low");
        end
        check_equal(got_q.size() - base, 0, "bytes written with fifo_en low");
        run_dump(1'b0, 12'h000);

        fill_buffer(boot_lines * bytes_per_line);   // new pattern for a second dump
        run_dump(1'b0, 12'h000);

        if (usb_dump_top_i.fifo_writer_i.usb_dump_assert_i.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failures in the FIFO writer");
        end
    end

endmodule

`default_nettype wire

// File: all.f
usb_dump_pkg.sv
text_rom.sv
sipo_buffer.sv
fifo_writer.sv
dump_sequencer.sv
usb_dump_top.sv
usb_dump_assert.sv
tb_usb_dump.sv

// File: Makefile
SRCS := $(shell cat all.f)

obj_dir/Vtb_usb_dump: all.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_usb_dump -f all.f

run: obj_dir/Vtb_usb_dump
	obj_dir/Vtb_usb_dump | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null

clean:
	rm -rf obj_dir

.PHONY: run clean
